// File: design/data_port.sv
// Load/store data port

module data_port (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         load_i,
  input  logic                         store_i,
  input  logic [mem_req_pkg::XLEN-1:0] addr_i,
  input  logic [mem_req_pkg::XLEN-1:0] wdata_i,
  input  mem_req_pkg::width_e          width_i,
  input  logic                         unsigned_i,
  output logic [mem_req_pkg::XLEN-1:0] load_data_o,
  output logic                         dhit_o,
  output logic                         data_fault_o,
  mem_req_if.requester                 req
);

  logic                              pending_q;
  logic                              write_q;
  logic                              unsigned_q;
  mem_req_pkg::width_e               width_q;
  logic [mem_req_pkg::OFS_W-1:0]     ofs_q;
  logic [mem_req_pkg::XLEN-1:0]      adr_q;
  logic [mem_req_pkg::XLEN-1:0]      wdata_q;
  logic [mem_req_pkg::SEL_W-1:0]     sel_q;

  logic                              start;
  logic                              misaligned;
  logic [mem_req_pkg::SEL_W-1:0]     sel_d;
  logic [mem_req_pkg::SHAMT_W-1:0]   wr_shift;
  logic [mem_req_pkg::SHAMT_W-1:0]   rd_shift;
  logic [mem_req_pkg::XLEN-1:0]      lane_word;
  logic [mem_req_pkg::XLEN-1:0]      ext_word;

  assign start = !pending_q && (load_i || store_i);

  // Lane selects and alignment check
  always_comb begin
    case (width_i)
      mem_req_pkg::WIDTH_BYTE: begin
        sel_d      = mem_req_pkg::SEL_BYTE << addr_i[mem_req_pkg::OFS_W-1:0];
        misaligned = 1'b0;
      end
      mem_req_pkg::WIDTH_HALF: begin
        sel_d      = mem_req_pkg::SEL_HALF << addr_i[mem_req_pkg::OFS_W-1:0];
        misaligned = addr_i[0];
      end
      default: begin
        sel_d      = mem_req_pkg::SEL_ALL;
        misaligned = |addr_i[mem_req_pkg::OFS_W-1:0];
      end
    endcase
  end

  // Byte offset scaled to a bit shift
  assign wr_shift = {addr_i[mem_req_pkg::OFS_W-1:0], {mem_req_pkg::BYTE_SH{1'b0}}};
  assign rd_shift = {ofs_q, {mem_req_pkg::BYTE_SH{1'b0}}};

  // Move the addressed lanes down, then extend
  assign lane_word = req.rdata >> rd_shift;

  always_comb begin
    case (width_q)
      mem_req_pkg::WIDTH_BYTE: begin
        ext_word = {{(mem_req_pkg::XLEN - mem_req_pkg::BYTE_W)
                     {~unsigned_q & lane_word[mem_req_pkg::BYTE_W-1]}},
                    lane_word[mem_req_pkg::BYTE_W-1:0]};
      end
      mem_req_pkg::WIDTH_HALF: begin
        ext_word = {{(mem_req_pkg::XLEN - 2 * mem_req_pkg::BYTE_W)
                     {~unsigned_q & lane_word[2*mem_req_pkg::BYTE_W-1]}},
                    lane_word[2*mem_req_pkg::BYTE_W-1:0]};
      end
      default: ext_word = req.rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pending_q    <= 1'b0;
      dhit_o       <= 1'b0;
      data_fault_o <= 1'b0;
    end else begin
      dhit_o       <= 1'b0;
      data_fault_o <= 1'b0;
      if (pending_q) begin
        if (req.done) begin
          pending_q <= 1'b0;
          dhit_o    <= 1'b1;
        end
      end else if (start) begin
        if (misaligned) begin
          data_fault_o <= 1'b1;
        end else begin
          pending_q <= 1'b1;
        end
      end
    end
  end

  // Request payload and load result
  always_ff @(posedge clk) begin
    if (start) begin
      write_q    <= store_i;
      unsigned_q <= unsigned_i;
      width_q    <= width_i;
      ofs_q      <= addr_i[mem_req_pkg::OFS_W-1:0];
      adr_q      <= {addr_i[mem_req_pkg::XLEN-1:mem_req_pkg::OFS_W],
                     {mem_req_pkg::OFS_W{1'b0}}};
      wdata_q    <= wdata_i << wr_shift;
      sel_q      <= sel_d;
    end
    if (pending_q && req.done && !write_q) begin
      load_data_o <= ext_word;
    end
  end

  assign req.read  = pending_q & ~write_q;
  assign req.write = pending_q & write_q;
  assign req.adr   = adr_q;
  assign req.wdata = wdata_q;
  assign req.sel   = sel_q;

  // A live request has lanes and one direction
  assert property (@(posedge clk) disable iff (reset_i)
    (req.read || req.write) |-> (req.sel != '0) && !(req.read && req.write));

endmodule

// File: design/fetch_port.sv
// Instruction fetch port

module fetch_port (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         fetch_i,
  input  logic [mem_req_pkg::XLEN-1:0] pc_i,
  output logic [mem_req_pkg::XLEN-1:0] instruction_o,
  output logic                         ihit_o,
  output logic                         fetch_fault_o,
  mem_req_if.requester                 req
);

  logic                         pending_q;
  logic [mem_req_pkg::XLEN-1:0] pc_q;
  logic                         misaligned;

  assign misaligned = |pc_i[mem_req_pkg::OFS_W-1:0];

  // Pending flag and hit/fault pulses
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pending_q     <= 1'b0;
      ihit_o        <= 1'b0;
      fetch_fault_o <= 1'b0;
    end else begin
      ihit_o        <= 1'b0;
      fetch_fault_o <= 1'b0;
      if (pending_q) begin
        if (req.done) begin
          pending_q <= 1'b0;
          ihit_o    <= 1'b1;
        end
      end else if (fetch_i) begin
        // Misaligned pc never reaches the bus
        if (misaligned) begin
          fetch_fault_o <= 1'b1;
        end else begin
          pending_q <= 1'b1;
        end
      end
    end
  end

  // Address and returned word
  always_ff @(posedge clk) begin
    if (!pending_q && fetch_i) begin
      pc_q <= pc_i;
    end
    if (pending_q && req.done) begin
      instruction_o <= req.rdata;
    end
  end

  // Always a full word read
  assign req.read  = pending_q;
  assign req.write = 1'b0;
  assign req.adr   = pc_q;
  assign req.wdata = '0;
  assign req.sel   = mem_req_pkg::SEL_ALL;

  // Completion only arrives for a live read, never a write
  assert property (@(posedge clk) disable iff (reset_i)
    req.done |-> (req.read && !req.write));

endmodule

// File: design/mem_req_if.sv
// Requester to arbiter bundle

interface mem_req_if;

  // Request side held until done
  logic                           read;
  logic                           write;
  logic [mem_req_pkg::XLEN-1:0]   adr;
  logic [mem_req_pkg::XLEN-1:0]   wdata;
  logic [mem_req_pkg::SEL_W-1:0]  sel;

  // Completion with rdata valid alongside done
  logic [mem_req_pkg::XLEN-1:0]   rdata;
  logic                           done;

  modport requester (
    output read,
    output write,
    output adr,
    output wdata,
    output sel,
    input  rdata,
    input  done
  );

  modport arbiter (
    input  read,
    input  write,
    input  adr,
    input  wdata,
    input  sel,
    output rdata,
    output done
  );

endinterface

// File: design/mem_req_pkg.sv
// Memory request unit definitions

package mem_req_pkg;

  // Word and byte-lane geometry
  localparam int XLEN    = 32;
  localparam int SEL_W   = 4;
  localparam int BYTE_W  = XLEN / SEL_W;
  localparam int OFS_W   = $clog2(SEL_W);
  localparam int BYTE_SH = $clog2(BYTE_W);
  localparam int SHAMT_W = $clog2(XLEN);

  // Byte select patterns before lane shifting
  localparam logic [SEL_W-1:0] SEL_BYTE = 4'b0001;
  localparam logic [SEL_W-1:0] SEL_HALF = 4'b0011;
  localparam logic [SEL_W-1:0] SEL_ALL  = 4'b1111;

  // Load/store access width
  typedef enum logic [1:0] {
    WIDTH_BYTE = 2'b00,
    WIDTH_HALF = 2'b01,
    WIDTH_WORD = 2'b10
  } width_e;

  // Arbiter FSM
  typedef enum logic [1:0] {
    ARB_IDLE = 2'b00,
    ARB_REQ  = 2'b01,
    ARB_WAIT = 2'b10
  } arb_state_e;

endpackage

// File: design/mem_request_top.sv
// Memory request unit top level

module mem_request_top (
  input  logic                          clk,
  input  logic                          reset_i,

  // Instruction fetch
  input  logic                          fetch_i,
  input  logic [mem_req_pkg::XLEN-1:0]  pc_i,
  output logic [mem_req_pkg::XLEN-1:0]  instruction_o,
  output logic                          ihit_o,
  output logic                          fetch_fault_o,

  // Load/store
  input  logic                          load_i,
  input  logic                          store_i,
  input  logic [mem_req_pkg::XLEN-1:0]  addr_i,
  input  logic [mem_req_pkg::XLEN-1:0]  wdata_i,
  input  mem_req_pkg::width_e           width_i,
  input  logic                          unsigned_i,
  output logic [mem_req_pkg::XLEN-1:0]  load_data_o,
  output logic                          dhit_o,
  output logic                          data_fault_o,

  // Bus master
  input  logic                          busy_i,
  input  logic [mem_req_pkg::XLEN-1:0]  dat_i,
  output logic [mem_req_pkg::XLEN-1:0]  dat_o,
  output logic [mem_req_pkg::XLEN-1:0]  adr_o,
  output logic [mem_req_pkg::SEL_W-1:0] sel_o,
  output logic                          read_o,
  output logic                          write_o
);

  mem_req_if fetch_bus ();
  mem_req_if data_bus ();

  fetch_port i_fetch_port (
    .clk           (clk),
    .reset_i       (reset_i),
    .fetch_i       (fetch_i),
    .pc_i          (pc_i),
    .instruction_o (instruction_o),
    .ihit_o        (ihit_o),
    .fetch_fault_o (fetch_fault_o),
    .req           (fetch_bus.requester)
  );

  data_port i_data_port (
    .clk          (clk),
    .reset_i      (reset_i),
    .load_i       (load_i),
    .store_i      (store_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .width_i      (width_i),
    .unsigned_i   (unsigned_i),
    .load_data_o  (load_data_o),
    .dhit_o       (dhit_o),
    .data_fault_o (data_fault_o),
    .req          (data_bus.requester)
  );

  request_arbiter i_request_arbiter (
    .clk       (clk),
    .reset_i   (reset_i),
    .fetch_req (fetch_bus.arbiter),
    .data_req  (data_bus.arbiter),
    .busy_i    (busy_i),
    .dat_i     (dat_i),
    .dat_o     (dat_o),
    .adr_o     (adr_o),
    .sel_o     (sel_o),
    .read_o    (read_o),
    .write_o   (write_o)
  );

endmodule

// File: design/request_arbiter.sv
// Bus request arbiter

module request_arbiter (
  input  logic                          clk,
  input  logic                          reset_i,
  mem_req_if.arbiter                    fetch_req,
  mem_req_if.arbiter                    data_req,
  input  logic                          busy_i,
  input  logic [mem_req_pkg::XLEN-1:0]  dat_i,
  output logic [mem_req_pkg::XLEN-1:0]  dat_o,
  output logic [mem_req_pkg::XLEN-1:0]  adr_o,
  output logic [mem_req_pkg::SEL_W-1:0] sel_o,
  output logic                          read_o,
  output logic                          write_o
);

  mem_req_pkg::arb_state_e      state_q;
  logic                         owner_data_q;
  logic                         seen_busy_q;
  logic                         done_q;
  logic                         write_q;
  logic [mem_req_pkg::XLEN-1:0] rdata_q;

  logic                         data_done;
  logic                         fetch_done;
  logic                         data_pend;
  logic                         fetch_pend;
  logic                         bus_end;

  assign data_done  = done_q & owner_data_q;
  assign fetch_done = done_q & ~owner_data_q;

  // A request completing this cycle is dropped next cycle, so mask it
  assign data_pend  = (data_req.read | data_req.write) & ~data_done;
  assign fetch_pend = (fetch_req.read | fetch_req.write) & ~fetch_done;

  // First low busy after it was seen high
  assign bus_end = (state_q == mem_req_pkg::ARB_WAIT) && seen_busy_q && !busy_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q      <= mem_req_pkg::ARB_IDLE;
      owner_data_q <= 1'b0;
      seen_busy_q  <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        mem_req_pkg::ARB_IDLE: begin
          // Data wins over fetch
          if (data_pend) begin
            owner_data_q <= 1'b1;
            state_q      <= mem_req_pkg::ARB_REQ;
          end else if (fetch_pend) begin
            owner_data_q <= 1'b0;
            state_q      <= mem_req_pkg::ARB_REQ;
          end
        end
        mem_req_pkg::ARB_REQ: begin
          seen_busy_q <= 1'b0;
          state_q     <= mem_req_pkg::ARB_WAIT;
        end
        mem_req_pkg::ARB_WAIT: begin
          if (busy_i) begin
            seen_busy_q <= 1'b1;
          end else if (seen_busy_q) begin
            done_q  <= 1'b1;
            state_q <= mem_req_pkg::ARB_IDLE;
          end
        end
        default: state_q <= mem_req_pkg::ARB_IDLE;
      endcase
    end
  end

  // Bus payload taken from the winner at grant
  always_ff @(posedge clk) begin
    if (state_q == mem_req_pkg::ARB_IDLE) begin
      if (data_pend) begin
        write_q <= data_req.write;
        adr_o   <= data_req.adr;
        sel_o   <= data_req.sel;
        dat_o   <= data_req.wdata;
      end else if (fetch_pend) begin
        write_q <= fetch_req.write;
        adr_o   <= fetch_req.adr;
        sel_o   <= fetch_req.sel;
        dat_o   <= fetch_req.wdata;
      end
    end
    if (bus_end) begin
      rdata_q <= dat_i;
    end
  end

  // One-cycle strobe while in ARB_REQ
  assign read_o  = (state_q == mem_req_pkg::ARB_REQ) & ~write_q;
  assign write_o = (state_q == mem_req_pkg::ARB_REQ) & write_q;

  // Completion goes back to the owner only
  assign data_req.done   = data_done;
  assign fetch_req.done  = fetch_done;
  assign data_req.rdata  = owner_data_q ? rdata_q : '0;
  assign fetch_req.rdata = owner_data_q ? '0 : rdata_q;

  // Strobes are single-cycle and exclusive
  assert property (@(posedge clk) disable iff (reset_i)
    (read_o || write_o) |-> !(read_o && write_o) ##1 !(read_o || write_o));

  // done lands only on a requester still holding its request
  assert property (@(posedge clk) disable iff (reset_i)
    done_q |-> (owner_data_q ? (data_req.read || data_req.write) : fetch_req.read));

endmodule

// File: filelist.f
design/mem_req_pkg.sv
design/mem_req_if.sv
design/fetch_port.sv
design/data_port.sv
design/request_arbiter.sv
design/mem_request_top.sv
verification/bus_slave_model.sv
verification/tb_mem_request.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f filelist.f --top-module tb_mem_request \
  -o sim_mem_request > build.log 2>&1 &&
  ./obj_dir/sim_mem_request > sim.log 2>&1 ||
  echo "Build or simulation run did not complete, see build.log and sim.log"

grep -qx "TESTS PASSED" sim.log && echo "Simulation result: pass" ||
  { echo "Simulation result: fail"; exit 1; }

// File: verification/bus_slave_model.sv
// Bus memory model

module bus_slave_model (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [2:0]                    latency_i,
  input  logic                          read_i,
  input  logic                          write_i,
  input  logic [mem_req_pkg::XLEN-1:0]  adr_i,
  input  logic [mem_req_pkg::XLEN-1:0]  dat_i,
  input  logic [mem_req_pkg::SEL_W-1:0] sel_i,
  output logic [mem_req_pkg::XLEN-1:0]  dat_o,
  output logic                          busy_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS = 16;

  logic [mem_req_pkg::XLEN-1:0] mem [WORDS];
  logic [2:0]                   count_q;
  logic [3:0]                   idx;

  // Start contents built from the byte address of each word
  function automatic logic [mem_req_pkg::XLEN-1:0] fill_word(input logic [3:0] w);
    logic [7:0] a;
    a = {2'b00, w, 2'b00};
    return {a ^ 8'hC3, ~a, a + 8'h5A, a};
  endfunction

  assign idx = adr_i[5:2];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= 3'd0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= fill_word(4'(i));
      end
    end else if (read_i || write_i) begin
      // Busy rises next cycle and lasts latency_i cycles
      count_q <= latency_i;
      dat_o   <= mem[idx];
      if (write_i) begin
        for (int b = 0; b < mem_req_pkg::SEL_W; b++) begin
          if (sel_i[b]) begin
            mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
    end else if (count_q != 3'd0) begin
      count_q <= count_q - 3'd1;
    end
  end

  assign busy_o = (count_q != 3'd0);

endmodule

// File: verification/tb_mem_request.sv
// Memory request unit testbench

module tb_mem_request;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_OPS       = 200;
  localparam int          CYCLES_PER_OP = 12;
  localparam int          MAX_CYCLES    = NUM_OPS * CYCLES_PER_OP;
  localparam int          WORDS         = 16;
  localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

  typedef struct packed {
    logic                         fault;
    logic                         check;
    logic [mem_req_pkg::XLEN-1:0] value;
  } resp_t;

  typedef struct packed {
    logic                          write;
    logic [mem_req_pkg::XLEN-1:0]  adr;
    logic [mem_req_pkg::SEL_W-1:0] sel;
    logic [mem_req_pkg::XLEN-1:0]  data;
  } bus_t;

  logic                          clk;
  logic                          reset_i;
  logic                          fetch_i;
  logic                          load_i;
  logic                          store_i;
  logic                          unsigned_i;
  logic [mem_req_pkg::XLEN-1:0]  pc_i;
  logic [mem_req_pkg::XLEN-1:0]  addr_i;
  logic [mem_req_pkg::XLEN-1:0]  wdata_i;
  mem_req_pkg::width_e           width_i;
  logic [mem_req_pkg::XLEN-1:0]  instruction_o;
  logic [mem_req_pkg::XLEN-1:0]  load_data_o;
  logic                          ihit_o;
  logic                          dhit_o;
  logic                          fetch_fault_o;
  logic                          data_fault_o;
  logic                          busy_i;
  logic [mem_req_pkg::XLEN-1:0]  dat_i;
  logic [mem_req_pkg::XLEN-1:0]  dat_o;
  logic [mem_req_pkg::XLEN-1:0]  adr_o;
  logic [mem_req_pkg::SEL_W-1:0] sel_o;
  logic                          read_o;
  logic                          write_o;
  logic [2:0]                    latency_q;

  logic [31:0]                   lfsr_q;
  logic [mem_req_pkg::XLEN-1:0]  shadow [WORDS];
  resp_t                         fetch_exp [$];
  resp_t                         data_exp [$];
  bus_t                          bus_exp [$];
  int                            cycles;
  int                            value_errors;
  int                            other_errors;
  int                            ihit_cycle;
  int                            dhit_cycle;

  mem_request_top i_dut (
    .clk           (clk),
    .reset_i       (reset_i),
    .fetch_i       (fetch_i),
    .pc_i          (pc_i),
    .instruction_o (instruction_o),
    .ihit_o        (ihit_o),
    .fetch_fault_o (fetch_fault_o),
    .load_i        (load_i),
    .store_i       (store_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .width_i       (width_i),
    .unsigned_i    (unsigned_i),
    .load_data_o   (load_data_o),
    .dhit_o        (dhit_o),
    .data_fault_o  (data_fault_o),
    .busy_i        (busy_i),
    .dat_i         (dat_i),
    .dat_o         (dat_o),
    .adr_o         (adr_o),
    .sel_o         (sel_o),
    .read_o        (read_o),
    .write_o       (write_o)
  );

  bus_slave_model i_slave (
    .clk       (clk),
    .reset_i   (reset_i),
    .latency_i (latency_q),
    .read_i    (read_o),
    .write_i   (write_o),
    .adr_i     (adr_o),
    .dat_i     (dat_o),
    .sel_i     (sel_o),
    .dat_o     (dat_i),
    .busy_o    (busy_i)
  );

  always #2 clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
    end
    return r;
  endfunction

  function automatic logic [31:0] fill_word(input logic [3:0] w);
    logic [7:0] a;
    a = {2'b00, w, 2'b00};
    return {a ^ 8'hC3, ~a, a + 8'h5A, a};
  endfunction

  function automatic mem_req_pkg::width_e pick_width(input logic [1:0] code);
    case (code)
      2'd0:    return mem_req_pkg::WIDTH_BYTE;
      2'd1:    return mem_req_pkg::WIDTH_HALF;
      default: return mem_req_pkg::WIDTH_WORD;
    endcase
  endfunction

  function automatic logic [31:0] align(input logic [31:0] a, input mem_req_pkg::width_e w);
    case (w)
      mem_req_pkg::WIDTH_BYTE: return a;
      mem_req_pkg::WIDTH_HALF: return a & ~32'd1;
      default:                 return a & ~32'd3;
    endcase
  endfunction

  function automatic logic is_misaligned(input logic [31:0] a, input mem_req_pkg::width_e w);
    case (w)
      mem_req_pkg::WIDTH_BYTE: return 1'b0;
      mem_req_pkg::WIDTH_HALF: return a[0];
      default:                 return |a[1:0];
    endcase
  endfunction

  // One lane per byte, two per half, all four per word
  function automatic logic [3:0] lane_sel(input logic [31:0] a, input mem_req_pkg::width_e w);
    case (w)
      mem_req_pkg::WIDTH_BYTE: return 4'b0001 << a[1:0];
      mem_req_pkg::WIDTH_HALF: return 4'b0011 << a[1:0];
      default:                 return 4'b1111;
    endcase
  endfunction

  // Expected load value from the stored word
  function automatic logic [31:0] ref_load(input logic [31:0] word, input logic [31:0] a,
                                           input mem_req_pkg::width_e w, input logic uns);
    logic [31:0] lanes;
    lanes = word >> {a[1:0], 3'b000};
    case (w)
      mem_req_pkg::WIDTH_BYTE: return uns ? {24'h0, lanes[7:0]} : {{24{lanes[7]}}, lanes[7:0]};
      mem_req_pkg::WIDTH_HALF: return uns ? {16'h0, lanes[15:0]} : {{16{lanes[15]}}, lanes[15:0]};
      default:                 return word;
    endcase
  endfunction

  function automatic logic [31:0] merge_store(input logic [31:0] word, input logic [31:0] a,
                                              input logic [31:0] wdata,
                                              input mem_req_pkg::width_e w);
    logic [31:0] lanes;
    logic [3:0]  sel;
    logic [31:0] r;
    lanes = wdata << {a[1:0], 3'b000};
    sel   = lane_sel(a, w);
    r     = word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        r[8*b +: 8] = lanes[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    other_errors++;
  endtask

  task automatic start_fetch(input logic [31:0] pc);
    resp_t r;
    bus_t  b;
    fetch_i <= 1'b1;
    pc_i    <= pc;
    r.fault = |pc[1:0];
    r.check = 1'b1;
    r.value = shadow[pc[5:2]];
    fetch_exp.push_back(r);
    if (!r.fault) begin
      b.write = 1'b0;
      b.adr   = pc;
      b.sel   = 4'hF;
      b.data  = '0;
      bus_exp.push_back(b);
    end
  endtask

  // Shadow memory follows stores as they are issued
  task automatic start_data(input logic store, input logic [31:0] a, input logic [31:0] wdata,
                            input mem_req_pkg::width_e w, input logic uns);
    resp_t r;
    bus_t  b;
    load_i     <= !store;
    store_i    <= store;
    addr_i     <= a;
    wdata_i    <= wdata;
    width_i    <= w;
    unsigned_i <= uns;
    r.fault = is_misaligned(a, w);
    r.check = !store;
    r.value = ref_load(shadow[a[5:2]], a, w, uns);
    data_exp.push_back(r);
    if (!r.fault) begin
      b.write = store;
      b.adr   = {a[31:2], 2'b00};
      b.sel   = lane_sel(a, w);
      b.data  = wdata << {a[1:0], 3'b000};
      bus_exp.push_back(b);
      if (store) begin
        shadow[a[5:2]] = merge_store(shadow[a[5:2]], a, wdata, w);
      end
    end
  endtask

  task automatic finish_op();
    @(posedge clk);
    fetch_i <= 1'b0;
    load_i  <= 1'b0;
    store_i <= 1'b0;
    while (fetch_exp.size() != 0 || data_exp.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic do_fetch(input logic [31:0] pc);
    @(posedge clk);
    latency_q <= 3'(rand_bits(2) + 32'd1);
    start_fetch(pc);
    finish_op();
  endtask

  task automatic do_data(input logic store, input logic [31:0] a, input logic [31:0] wdata,
                         input mem_req_pkg::width_e w, input logic uns);
    @(posedge clk);
    latency_q <= 3'(rand_bits(2) + 32'd1);
    start_data(store, a, wdata, w, uns);
    finish_op();
  endtask

  // Data wins the bus and is queued first
  task automatic do_pair(input logic store, input logic [31:0] a, input logic [31:0] wdata,
                         input mem_req_pkg::width_e w, input logic uns,
                         input logic [31:0] pc);
    @(posedge clk);
    latency_q <= 3'(rand_bits(2) + 32'd1);
    start_data(store, a, wdata, w, uns);
    start_fetch(pc);
    finish_op();
  endtask

  // Compare responses and bus strobes with the queued expectations
  always @(negedge clk) begin
    resp_t r;
    bus_t  b;
    if (!reset_i) begin
      if (ihit_o || fetch_fault_o) begin
        if (fetch_exp.size() == 0) begin
          report_error("fetch response with no fetch outstanding");
        end else begin
          r = fetch_exp.pop_front();
          check_value("fetch_fault_o", 32'(r.fault), 32'(fetch_fault_o));
          check_value("ihit_o", 32'(!r.fault), 32'(ihit_o));
          if (ihit_o && !r.fault) begin
            check_value("instruction_o", r.value, instruction_o);
          end
          if (ihit_o) begin
            ihit_cycle = cycles;
          end
        end
      end
      if (dhit_o || data_fault_o) begin
        if (data_exp.size() == 0) begin
          report_error("data response with no load or store outstanding");
        end else begin
          r = data_exp.pop_front();
          check_value("data_fault_o", 32'(r.fault), 32'(data_fault_o));
          check_value("dhit_o", 32'(!r.fault), 32'(dhit_o));
          if (dhit_o && r.check) begin
            check_value("load_data_o", r.value, load_data_o);
          end
          if (dhit_o) begin
            dhit_cycle = cycles;
          end
        end
      end
      if (read_o || write_o) begin
        if (bus_exp.size() == 0) begin
          report_error("bus strobe with no request outstanding");
        end else begin
          b = bus_exp.pop_front();
          check_value("write_o", 32'(b.write), 32'(write_o));
          check_value("read_o", 32'(!b.write), 32'(read_o));
          check_value("adr_o", b.adr, adr_o);
          check_value("sel_o", 32'(b.sel), 32'(sel_o));
          if (b.write) begin
            check_value("dat_o", b.data, dat_o);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with responses still outstanding", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0]         a;
    mem_req_pkg::width_e w;
    int                  kind;
    clk          = 1'b0;
    reset_i      = 1'b1;
    fetch_i      = 1'b0;
    load_i       = 1'b0;
    store_i      = 1'b0;
    unsigned_i   = 1'b0;
    pc_i         = '0;
    addr_i       = '0;
    wdata_i      = '0;
    width_i      = mem_req_pkg::WIDTH_WORD;
    latency_q    = 3'd1;
    lfsr_q       = 32'd73354;
    cycles       = 0;
    value_errors = 0;
    other_errors = 0;
    ihit_cycle   = 0;
    dhit_cycle   = 0;
    for (int i = 0; i < WORDS; i++) begin
      shadow[i] = fill_word(4'(i));
    end

    repeat (8) @(posedge clk);
    reset_i <= 1'b0;

    // Quiet outputs after reset
    repeat (3) begin
      @(negedge clk);
      check_value("read_o", 32'd0, 32'(read_o));
      check_value("write_o", 32'd0, 32'(write_o));
      check_value("ihit_o", 32'd0, 32'(ihit_o));
      check_value("dhit_o", 32'd0, 32'(dhit_o));
      check_value("fetch_fault_o", 32'd0, 32'(fetch_fault_o));
      check_value("data_fault_o", 32'd0, 32'(data_fault_o));
    end

    // Store of each width, then read back the merged word
    for (int k = 0; k < 3; k++) begin
      w = pick_width(2'(k));
      a = align(rand_bits(6), w);
      do_data(1'b1, a, rand_bits(32), w, 1'b0);
      do_data(1'b0, a & ~32'd3, 32'h0, mem_req_pkg::WIDTH_WORD, 1'b0);
    end

    repeat (8) do_fetch(align(rand_bits(6), mem_req_pkg::WIDTH_WORD));

    for (int k = 0; k < 3; k++) begin
      for (int u = 0; u < 2; u++) begin
        w = pick_width(2'(k));
        repeat (2) do_data(1'b0, align(rand_bits(6), w), 32'h0, w, u[0]);
      end
    end

    // Misaligned accesses never reach the bus
    do_fetch(32'h5);
    do_fetch(32'h2);
    do_data(1'b0, 32'h9, 32'h0, mem_req_pkg::WIDTH_HALF, 1'b0);
    do_data(1'b1, 32'h1E, 32'h1234_5678, mem_req_pkg::WIDTH_WORD, 1'b0);

    do_pair(1'b0, align(rand_bits(6), mem_req_pkg::WIDTH_WORD), 32'h0,
            mem_req_pkg::WIDTH_HALF, 1'b0, align(rand_bits(6), mem_req_pkg::WIDTH_WORD));
    if (dhit_cycle >= ihit_cycle) begin
      report_error("fetch hit arrived before the data hit");
    end

    // Random mix of mostly aligned operations
    repeat (80) begin
      kind = rand_bits(2);
      w    = pick_width(2'(rand_bits(2)));
      a    = rand_bits(6);
      if (rand_bits(2) != 32'd0) begin
        a = align(a, w);
      end
      case (kind)
        0: do_fetch(align(a, mem_req_pkg::WIDTH_WORD) | (rand_bits(3) == 32'd0 ? 32'd1 : 32'd0));
        1: do_data(1'b0, a, 32'h0, w, rand_bits(1) != 32'd0);
        2: do_data(1'b1, a, rand_bits(32), w, 1'b0);
        default: do_pair(rand_bits(1) != 32'd0, a, rand_bits(32), w, rand_bits(1) != 32'd0,
                         align(rand_bits(6), mem_req_pkg::WIDTH_WORD));
      endcase
    end

    repeat (4) @(posedge clk);
    if (bus_exp.size() != 0) begin
      report_error("bus transfers expected but never seen");
    end
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
